// File: cache_types_pkg.sv
package cache_types_pkg;

    // ********************
    // geometry
    // ********************
    localparam int WORD_W            = 32;
    localparam int BLOCK_SIZE        = 4;  // words per block.
    localparam int BLOCK_OFF_LEN     = 2;
    localparam int NUM_WAYS          = 2;
    localparam int WAYS_LEN          = 1;
    localparam int NUM_SETS_PER_BANK = 4;
    localparam int BANKS_LEN         = 1;
    localparam int INDEX_LEN         = 3;  // index bit 0 picks the bank.
    localparam int TAG_LEN           = 32 - INDEX_LEN - BLOCK_OFF_LEN - 2;

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [TAG_LEN-1:0]       tag_t;
    typedef logic [INDEX_LEN-1:0]     index_t;
    typedef logic [BLOCK_OFF_LEN-1:0] offset_t;
    typedef logic [WAYS_LEN-1:0]      way_t;
    typedef logic [1:0]               age_t;  // saturates at 3.

    // ********************
    // structures
    // ********************
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    block_offset;
        logic [1:0] byte_offset;
    } cache_addr_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        tag_t                       tag;
        word_t [BLOCK_SIZE-1:0]     block;
    } cache_frame_t;

    typedef struct packed {
        logic        valid;
        cache_addr_t block_addr;     // offsets are zero.
        logic        write_pending;  // miss came from a write.
    } mshr_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        VICTIM_EJECT,
        BLOCK_PULL,
        FINISH
    } bank_state_t;

endpackage

// File: cache_bank_if.sv
interface cache_bank_if;

    logic                        req_valid;  // one cycle per request.
    logic                        req_write;
    cache_types_pkg::cache_addr_t req_addr;
    cache_types_pkg::word_t      req_wdata;

    logic                        hit;        // same cycle as req_valid.
    cache_types_pkg::word_t      rdata;
    logic                        busy;
    logic                        fill_done;  // pulse on leaving FINISH.

    logic                        miss_alloc;
    cache_types_pkg::mshr_entry_t entry;

    modport router (
        output req_valid, req_write, req_addr, req_wdata, miss_alloc,
        input  hit, rdata, busy, fill_done
    );

    modport mshr (
        input  miss_alloc, req_write, req_addr, fill_done,
        output entry
    );

    modport bank (
        input  req_valid, req_write, req_addr, req_wdata, entry,
        output hit, rdata, busy, fill_done
    );

endinterface

// File: ram_if.sv
interface ram_if;

    // request held with a stable address until complete.
    logic                         ren;
    logic                         wen;
    cache_types_pkg::cache_addr_t addr;
    cache_types_pkg::word_t       store;
    cache_types_pkg::word_t       data;      // valid with complete.
    logic                         complete;

    modport bank (
        output ren, wen, addr, store,
        input  data, complete
    );

    modport arbiter (
        input  ren, wen, addr, store,
        output data, complete
    );

endinterface

// File: apb_request_router.sv
module apb_request_router (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [31:0]            PADDR,
    input  cache_types_pkg::word_t PWDATA,
    output cache_types_pkg::word_t PRDATA,
    output logic                   PREADY,
    cache_bank_if.router           bank0,
    cache_bank_if.router           bank1
);

    typedef enum logic [1:0] {
        SETUP,
        LOOKUP,
        WAIT_FILL,
        REPLAY
    } router_state_t;

    router_state_t                state, next_state;
    cache_types_pkg::cache_addr_t addr;
    cache_types_pkg::word_t       rdata;
    logic                         sel;
    logic                         issue;
    logic                         hit;
    logic                         busy;
    logic                         fill_done;

    assign addr = cache_types_pkg::cache_addr_t'(PADDR);
    assign sel  = addr.index[0];

    assign hit       = sel ? bank1.hit       : bank0.hit;
    assign rdata     = sel ? bank1.rdata     : bank0.rdata;
    assign busy      = sel ? bank1.busy      : bank0.busy;
    assign fill_done = sel ? bank1.fill_done : bank0.fill_done;

    // APB holds address and data for the whole transfer.
    assign issue = ((state == SETUP) && PSEL && !busy) || (state == REPLAY);

    assign bank0.req_valid  = issue && !sel;
    assign bank1.req_valid  = issue && sel;
    assign bank0.miss_alloc = issue && !sel && !hit;
    assign bank1.miss_alloc = issue && sel && !hit;

    assign bank0.req_write = PWRITE;
    assign bank1.req_write = PWRITE;
    assign bank0.req_addr  = addr;
    assign bank1.req_addr  = addr;
    assign bank0.req_wdata = PWDATA;
    assign bank1.req_wdata = PWDATA;

    assign PREADY = (state == LOOKUP) && PENABLE;  // access phase of an answered lookup.

    always_comb begin
        next_state = state;
        case (state)
            SETUP, REPLAY: begin
                if (issue) begin
                    next_state = hit ? LOOKUP : WAIT_FILL;
                end
            end
            LOOKUP:    next_state = SETUP;
            WAIT_FILL: if (fill_done) next_state = REPLAY;
            default:   next_state = SETUP;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= SETUP;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue && hit && !PWRITE) begin
            PRDATA <= rdata;
        end
    end

endmodule

// File: mshr_unit.sv
module mshr_unit (
    input logic        CLK,
    input logic        nRST,
    cache_bank_if.mshr mshr
);

    logic                         valid;
    cache_types_pkg::cache_addr_t block_addr;
    logic                         write_pending;

    assign mshr.entry = '{valid: valid, block_addr: block_addr, write_pending: write_pending};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= 1'b0;
        end else if (mshr.miss_alloc) begin
            valid <= 1'b1;
        end else if (mshr.fill_done) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (mshr.miss_alloc) begin
            block_addr              <= mshr.req_addr;
            block_addr.block_offset <= '0;  // block aligned.
            block_addr.byte_offset  <= '0;
            write_pending           <= mshr.req_write;
        end
    end

    // one outstanding miss per bank.
    a_single_miss: assert property (
        @(posedge CLK) disable iff (!nRST) mshr.miss_alloc |-> !valid
    );

    // the bank only finishes a refill that was allocated.
    a_fill_owned: assert property (
        @(posedge CLK) disable iff (!nRST) mshr.fill_done |-> valid
    );

endmodule

// File: cache_bank.sv
module cache_bank #(
    parameter logic BANK_ID = 1'b0
) (
    input logic        CLK,
    input logic        nRST,
    cache_bank_if.bank core,
    ram_if.bank        ram
);

    localparam int SET_LEN = cache_types_pkg::INDEX_LEN - cache_types_pkg::BANKS_LEN;
    localparam int SETS    = cache_types_pkg::NUM_SETS_PER_BANK;
    localparam int WAYS    = cache_types_pkg::NUM_WAYS;

    typedef logic [SET_LEN-1:0] set_t;

    cache_types_pkg::cache_frame_t frames [SETS][WAYS];
    cache_types_pkg::age_t         ages [SETS][WAYS];

    cache_types_pkg::bank_state_t  state, next_state;
    cache_types_pkg::offset_t      count;
    cache_types_pkg::cache_frame_t eject_buf;
    cache_types_pkg::cache_frame_t victim;
    cache_types_pkg::word_t [cache_types_pkg::BLOCK_SIZE-1:0] pull_buf;

    set_t                          req_set, miss_set, fill_set;
    cache_types_pkg::way_t         hit_way, victim_way, fill_way;
    logic                          hit;
    logic                          last_word;

    function automatic cache_types_pkg::age_t age_inc(input cache_types_pkg::age_t a);
        return (a == '1) ? a : a + 1'b1;
    endfunction

    assign req_set   = core.req_addr.index[cache_types_pkg::INDEX_LEN-1:cache_types_pkg::BANKS_LEN];
    assign miss_set  = core.entry.block_addr.index[cache_types_pkg::INDEX_LEN-1:cache_types_pkg::BANKS_LEN];
    assign last_word = (count == cache_types_pkg::offset_t'(cache_types_pkg::BLOCK_SIZE - 1));

    // ********************
    // lookup
    // ********************
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (core.req_valid && frames[req_set][w].valid &&
                (frames[req_set][w].tag == core.req_addr.tag)) begin
                hit     = 1'b1;
                hit_way = cache_types_pkg::way_t'(w);
            end
        end
    end

    assign core.hit   = hit;
    assign core.rdata = frames[req_set][hit_way].block[core.req_addr.block_offset];

    // oldest way of the missing set, lowest way on a tie.
    always_comb begin
        victim_way = '0;
        for (int w = 1; w < WAYS; w++) begin
            if (ages[miss_set][w] > ages[miss_set][victim_way]) begin
                victim_way = cache_types_pkg::way_t'(w);
            end
        end
    end

    assign victim = frames[miss_set][victim_way];

    // ********************
    // refill
    // ********************
    always_comb begin
        next_state = state;
        case (state)
            cache_types_pkg::IDLE: begin
                if (core.entry.valid) begin
                    next_state = (victim.valid && victim.dirty) ?
                                 cache_types_pkg::VICTIM_EJECT : cache_types_pkg::BLOCK_PULL;
                end
            end
            cache_types_pkg::VICTIM_EJECT: begin
                if (ram.complete && last_word) next_state = cache_types_pkg::BLOCK_PULL;
            end
            cache_types_pkg::BLOCK_PULL: begin
                if (ram.complete && last_word) next_state = cache_types_pkg::FINISH;
            end
            default: next_state = cache_types_pkg::IDLE;  // FINISH lasts one cycle.
        endcase
    end

    assign ram.wen   = (state == cache_types_pkg::VICTIM_EJECT);
    assign ram.ren   = (state == cache_types_pkg::BLOCK_PULL);
    assign ram.store = eject_buf.block[count];
    assign ram.addr  = ram.wen ?
        '{tag: eject_buf.tag, index: {fill_set, BANK_ID}, block_offset: count, byte_offset: 2'b00} :
        '{tag: core.entry.block_addr.tag, index: core.entry.block_addr.index,
          block_offset: count, byte_offset: 2'b00};

    assign core.fill_done = (state == cache_types_pkg::FINISH);
    assign core.busy      = (state != cache_types_pkg::IDLE) || core.entry.valid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= cache_types_pkg::IDLE;
            count  <= '0;
            frames <= '{default: '0};
            ages   <= '{default: '0};
        end else begin
            state <= next_state;
            if (ram.complete) begin
                count <= last_word ? '0 : count + 1'b1;
            end
            if (hit && core.req_write) begin
                frames[req_set][hit_way].block[core.req_addr.block_offset] <= core.req_wdata;
                frames[req_set][hit_way].dirty <= 1'b1;
            end
            if (state == cache_types_pkg::FINISH) begin
                frames[fill_set][fill_way] <= '{valid: 1'b1, dirty: 1'b0,
                                               tag: core.entry.block_addr.tag, block: pull_buf};
            end
            if (hit) begin
                for (int w = 0; w < WAYS; w++) begin
                    ages[req_set][w] <= (cache_types_pkg::way_t'(w) == hit_way) ?
                                        '0 : age_inc(ages[req_set][w]);
                end
            end else if (state == cache_types_pkg::FINISH) begin
                for (int w = 0; w < WAYS; w++) begin
                    ages[fill_set][w] <= (cache_types_pkg::way_t'(w) == fill_way) ?
                                         '0 : age_inc(ages[fill_set][w]);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == cache_types_pkg::IDLE) && core.entry.valid) begin
            eject_buf <= victim;
            fill_set  <= miss_set;
            fill_way  <= victim_way;
        end
        if ((state == cache_types_pkg::BLOCK_PULL) && ram.complete) begin
            pull_buf[count] <= ram.data;
        end
    end

    // a request stays up with the same address until the arbiter completes it.
    a_req_held: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((ram.ren || ram.wen) && !ram.complete) |=> ((ram.ren || ram.wen) && $stable(ram.addr))
    );

endmodule

// File: ram_arbiter.sv
module ram_arbiter (
    input  logic                   CLK,
    input  logic                   nRST,
    ram_if.arbiter                 bank0,
    ram_if.arbiter                 bank1,
    output logic                   ram_ren,
    output logic                   ram_wen,
    output logic [31:0]            ram_addr,
    output cache_types_pkg::word_t ram_wdata,
    input  cache_types_pkg::word_t ram_rdata,
    input  logic                   ram_complete
);

    logic granted;
    logic owner;   // granted bank.
    logic prefer;  // winner of the next tie.
    logic req0, req1;

    assign req0 = bank0.ren || bank0.wen;
    assign req1 = bank1.ren || bank1.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            granted <= 1'b0;
            owner   <= 1'b0;
            prefer  <= 1'b0;
        end else if (!granted) begin
            if (req0 || req1) begin
                granted <= 1'b1;
                owner   <= (req0 && req1) ? prefer : req1;
                prefer  <= (req0 && req1) ? !prefer : !req1;
            end
        end else if (!(owner ? req1 : req0)) begin
            granted <= 1'b0;  // refill over.
        end
    end

    assign ram_ren   = granted && (owner ? bank1.ren : bank0.ren);
    assign ram_wen   = granted && (owner ? bank1.wen : bank0.wen);
    assign ram_addr  = owner ? bank1.addr : bank0.addr;
    assign ram_wdata = owner ? bank1.store : bank0.store;

    assign bank0.data     = ram_rdata;
    assign bank1.data     = ram_rdata;
    assign bank0.complete = granted && !owner && ram_complete;
    assign bank1.complete = granted && owner && ram_complete;

    a_complete_granted: assert property (
        @(posedge CLK) disable iff (!nRST) ram_complete |-> (ram_ren || ram_wen)
    );

endmodule

// File: cache_top.sv
module cache_top (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   PSEL,
    input  logic                   PENABLE,
    input  logic                   PWRITE,
    input  logic [31:0]            PADDR,
    input  cache_types_pkg::word_t PWDATA,
    output cache_types_pkg::word_t PRDATA,
    output logic                   PREADY,
    output logic                   ram_ren,
    output logic                   ram_wen,
    output logic [31:0]            ram_addr,
    output cache_types_pkg::word_t ram_wdata,
    input  cache_types_pkg::word_t ram_rdata,
    input  logic                   ram_complete
);

    localparam int NUM_BANKS = 2 ** cache_types_pkg::BANKS_LEN;

    cache_bank_if bank_bus [NUM_BANKS] ();
    ram_if        ram_bus  [NUM_BANKS] ();

    apb_request_router i_router (
        .CLK,
        .nRST,
        .PSEL,
        .PENABLE,
        .PWRITE,
        .PADDR,
        .PWDATA,
        .PRDATA,
        .PREADY,
        .bank0   (bank_bus[0]),
        .bank1   (bank_bus[1])
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mshr_unit i_mshr (
            .CLK,
            .nRST,
            .mshr (bank_bus[b])
        );

        cache_bank #(
            .BANK_ID (1'(b))
        ) i_bank (
            .CLK,
            .nRST,
            .core (bank_bus[b]),
            .ram  (ram_bus[b])
        );
    end

    ram_arbiter i_arbiter (
        .CLK,
        .nRST,
        .bank0        (ram_bus[0]),
        .bank1        (ram_bus[1]),
        .ram_ren,
        .ram_wen,
        .ram_addr,
        .ram_wdata,
        .ram_rdata,
        .ram_complete
    );

endmodule

// File: cache_tb_mem.sv
module cache_tb_mem #(
    parameter int          WORDS = 1024,
    parameter int unsigned SEED  = 32'h1
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   ren,
    input  logic                   wen,
    input  logic [31:0]            addr,
    input  cache_types_pkg::word_t wdata,
    output cache_types_pkg::word_t rdata,
    output logic                   complete
);

    localparam int IDX_W = $clog2(WORDS);

    cache_types_pkg::word_t mem [WORDS];  // reference memory.
    int unsigned            seed;
    int                     left;
    logic                   pending;

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (i * 4) ^ 32'h5a5a_0000;  // byte address xor pattern.
        end
        rdata    = '0;
        complete = 1'b0;
        pending  = 1'b0;
        seed     = SEED;
        left     = $urandom(seed);  // seeds this process once.
        forever begin
            @(posedge CLK);
            if (!nRST) begin
                complete <= 1'b0;
                pending = 1'b0;
            end else if (complete) begin
                complete <= 1'b0;  // one-cycle pulse, next word starts after it.
            end else if (ren || wen) begin
                if (!pending) begin
                    pending = 1'b1;
                    left    = $urandom % 4 + 1;
                end
                left = left - 1;
                if (left == 0) begin
                    pending = 1'b0;
                    if (wen) begin
                        mem[addr[IDX_W+1:2]] = wdata;
                    end
                    rdata    <= mem[addr[IDX_W+1:2]];
                    complete <= 1'b1;
                end
            end
        end
    end

endmodule

// File: cache_tb.sv
module cache_tb;

    localparam int          MEM_WORDS      = 1024;          // tests stay below 4 KB.
    localparam int unsigned SEED           = 32'h9add_7a55;
    localparam int          TIMEOUT_CYCLES = 40 * 500;      // about 40 transfers, none near 500.

    logic                   CLK = 1'b0;
    logic                   nRST;
    logic                   PSEL;
    logic                   PENABLE;
    logic                   PWRITE;
    logic [31:0]            PADDR;
    cache_types_pkg::word_t PWDATA;
    cache_types_pkg::word_t PRDATA;
    logic                   PREADY;
    logic                   ram_ren;
    logic                   ram_wen;
    logic [31:0]            ram_addr;
    cache_types_pkg::word_t ram_wdata;
    cache_types_pkg::word_t ram_rdata;
    logic                   ram_complete;

    cache_types_pkg::word_t shadow [MEM_WORDS];  // expected memory contents.
    int                     errors      = 0;
    int                     cycle_count = 0;

    cache_top i_cache_top (
        .CLK,
        .nRST,
        .PSEL,
        .PENABLE,
        .PWRITE,
        .PADDR,
        .PWDATA,
        .PRDATA,
        .PREADY,
        .ram_ren,
        .ram_wen,
        .ram_addr,
        .ram_wdata,
        .ram_rdata,
        .ram_complete
    );

    cache_tb_mem #(
        .WORDS (MEM_WORDS),
        .SEED  (SEED)
    ) i_mem (
        .CLK,
        .nRST,
        .ren      (ram_ren),
        .wen      (ram_wen),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata),
        .complete (ram_complete)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ********************
    // APB access
    // ********************
    function automatic logic [31:0] word_addr(input int tag, input int index, input int offset);
        cache_types_pkg::cache_addr_t a;
        a              = '0;
        a.tag          = cache_types_pkg::tag_t'(tag);
        a.index        = cache_types_pkg::index_t'(index);
        a.block_offset = cache_types_pkg::offset_t'(offset);
        return a;
    endfunction

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input cache_types_pkg::word_t wdata,
                                output cache_types_pkg::word_t rdata, output int cycles);
        @(posedge CLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= write;
        PADDR   <= addr;
        PWDATA  <= wdata;
        @(posedge CLK);
        PENABLE <= 1'b1;
        cycles = 2;
        @(negedge CLK);
        while (!PREADY) begin
            @(negedge CLK);
            cycles++;
        end
        rdata = PRDATA;
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic check_latency(input string test, input logic [31:0] addr,
                                 input logic expect_hit, input int cycles);
        if (expect_hit && cycles != 2) begin
            errors++;
            $display("CHECK FAILED %s: hit on %h expected 2 cycles, actual %0d",
                     test, addr, cycles);
        end
        if (!expect_hit && cycles <= 2) begin
            errors++;
            $display("CHECK FAILED %s: miss on %h expected more than 2 cycles, actual %0d",
                     test, addr, cycles);
        end
    endtask

    task automatic apb_write(input string test, input logic [31:0] addr,
                             input cache_types_pkg::word_t data, input logic expect_hit);
        cache_types_pkg::word_t ignored;
        int                     cycles;
        apb_transfer(1'b1, addr, data, ignored, cycles);
        shadow[addr[11:2]] = data;
        check_latency(test, addr, expect_hit, cycles);
    endtask

    task automatic apb_read(input string test, input logic [31:0] addr, input logic expect_hit);
        cache_types_pkg::word_t data;
        int                     cycles;
        apb_transfer(1'b0, addr, '0, data, cycles);
        if (data !== shadow[addr[11:2]]) begin
            errors++;
            $display("CHECK FAILED %s: read %h expected %h, actual %h",
                     test, addr, shadow[addr[11:2]], data);
        end
        check_latency(test, addr, expect_hit, cycles);
    endtask

    // ********************
    // directed tests
    // ********************
    task automatic read_miss_fill();
        for (int i = 0; i < 4; i++) begin
            apb_read("read_miss_fill", word_addr(1, i, i), 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            apb_read("read_miss_fill", word_addr(1, i, i), 1'b1);
            apb_read("read_miss_fill", word_addr(1, i, 3 - i), 1'b1);
        end
    endtask

    task automatic write_hit();
        apb_write("write_hit", word_addr(1, 0, 1), 32'h1234_5678, 1'b1);
        for (int off = 0; off < 4; off++) begin
            apb_read("write_hit", word_addr(1, 0, off), 1'b1);
        end
    endtask

    task automatic bank_interleave();
        for (int t = 3; t < 5; t++) begin
            apb_read("bank_interleave", word_addr(t, 4, 0), 1'b0);  // bank 0.
            apb_read("bank_interleave", word_addr(t, 5, 0), 1'b0);  // bank 1.
        end
        for (int t = 3; t < 5; t++) begin
            apb_read("bank_interleave", word_addr(t, 4, t - 1), 1'b1);
            apb_read("bank_interleave", word_addr(t, 5, t - 1), 1'b1);
        end
    endtask

    task automatic dirty_eviction();
        logic [31:0] addr_a;
        addr_a = word_addr(5, 6, 2);
        apb_write("dirty_eviction", addr_a, 32'hdead_0a0a, 1'b0);
        apb_write("dirty_eviction", word_addr(6, 6, 1), 32'hbeef_0b0b, 1'b0);
        apb_read("dirty_eviction", word_addr(7, 6, 0), 1'b0);  // pushes out A.
        apb_read("dirty_eviction", addr_a, 1'b0);
        if (i_mem.mem[addr_a[11:2]] !== shadow[addr_a[11:2]]) begin
            errors++;
            $display("CHECK FAILED dirty_eviction: RAM word %h expected %h, actual %h",
                     addr_a, shadow[addr_a[11:2]], i_mem.mem[addr_a[11:2]]);
        end
    endtask

    task automatic lru_order();
        apb_read("lru_order", word_addr(8, 7, 0), 1'b0);
        apb_read("lru_order", word_addr(9, 7, 1), 1'b0);
        apb_read("lru_order", word_addr(8, 7, 3), 1'b1);   // A is now the newer way.
        apb_read("lru_order", word_addr(10, 7, 2), 1'b0);
        apb_read("lru_order", word_addr(8, 7, 0), 1'b1);
        apb_read("lru_order", word_addr(9, 7, 1), 1'b0);   // B was the victim.
    endtask

    initial begin
        nRST    = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        read_miss_fill();
        write_hit();
        bank_interleave();
        dirty_eviction();
        lru_order();

        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
cache_types_pkg.sv
cache_bank_if.sv
ram_if.sv
apb_request_router.sv
mshr_unit.sv
cache_bank.sv
ram_arbiter.sv
cache_top.sv
cache_tb_mem.sv
cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - files:
      - cache_types_pkg.sv
      - cache_bank_if.sv
      - ram_if.sv
      - apb_request_router.sv
      - mshr_unit.sv
      - cache_bank.sv
      - ram_arbiter.sv
      - cache_top.sv
  - target: test
    files:
      - cache_tb_mem.sv
      - cache_tb.sv
